// ==== common/csr_pkg.sv ====
//////////////////////////////////////////////////
// CSR front end host-side definitions
// MMIO widths, transaction id and local word map
//////////////////////////////////////////////////
`default_nettype none

package csr_pkg;

    // Host MMIO address in 4-byte units
    typedef logic [15:0] t_mmio_addr;

    // Read and write payload of one MMIO access
    typedef logic [63:0] t_mmio_data;

    // Transaction id carried from request to response
    typedef logic [8:0] t_tid;

    // Local 8-byte word index taken from address bits 3 to 1
    typedef logic [2:0] t_csr_word;

    // Local register map in 8-byte words
    localparam t_csr_word CSR_DFH       = 3'd0;
    localparam t_csr_word CSR_ID_L      = 3'd1;
    localparam t_csr_word CSR_ID_H      = 3'd2;
    localparam t_csr_word CSR_RSVD0     = 3'd3;
    localparam t_csr_word CSR_RSVD1     = 3'd4;
    localparam t_csr_word CSR_SCRATCH   = 3'd5;
    localparam t_csr_word CSR_SREG_ADDR = 3'd6;
    localparam t_csr_word CSR_SREG_DATA = 3'd7;

    // Feature type of an AFU, placed in header bits 63 to 60
    localparam logic [3:0] DFH_TYPE_AFU = 4'h1;

    // Byte offset to the next feature, placed in header bits 39 to 16
    localparam logic [23:0] DFH_NEXT_OFFSET = 24'h40;

endpackage

`default_nettype wire

// ==== common/sreg_pkg.sv ====
//////////////////////////////////////////////////
// System register file definitions
//////////////////////////////////////////////////
`default_nettype none

package sreg_pkg;

    // Number of system registers behind the data window
    localparam int SREG_COUNT = 16;

    // Index of one system register
    typedef logic [$clog2(SREG_COUNT)-1:0] t_sreg_addr;

    // Contents of one system register
    typedef logic [63:0] t_sreg_data;

endpackage

`default_nettype wire

// ==== rtl/afu_csr_top.sv ====
//////////////////////////////////////////////////
// AFU CSR front end
// Host MMIO decode, local registers and sreg path
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module afu_csr_top
    import csr_pkg::*;
    import sreg_pkg::*;
#(
    parameter logic [127:0] AFU_ID       = 128'h9d73_e8f2_58e9_4b5a_a1b4_6c0e_2f31_d7a5,
    parameter int           SREG_LATENCY = 3
)
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       mmio_rd_valid,
    input  wire logic       mmio_wr_valid,
    input  wire t_mmio_addr mmio_addr,
    input  wire t_tid       mmio_tid,
    input  wire t_mmio_data mmio_wr_data,
    output logic            rsp_valid,
    output t_tid            rsp_tid,
    output t_mmio_data      rsp_data
);

    // Dispatch strobes and payload
    logic       local_rd;
    t_csr_word  rd_word;
    t_tid       rd_tid;
    logic       sreg_rd;
    t_tid       sreg_rd_tid;
    logic       wr_en;
    t_csr_word  wr_word;
    t_mmio_data wr_data;

    // Register state and the sreg return path
    t_mmio_data scratch;
    t_sreg_addr sreg_addr;
    logic       file_rd_valid;
    t_sreg_data file_rd_data;
    logic       held_valid;
    t_tid       held_tid;
    t_sreg_data held_data;
    logic       held_taken;

    csr_dispatch i_csr_dispatch (
        .clk, .reset, .mmio_rd_valid, .mmio_wr_valid, .mmio_addr, .mmio_tid, .mmio_wr_data,
        .local_rd, .rd_word, .rd_tid, .sreg_rd, .sreg_rd_tid, .wr_en, .wr_word, .wr_data
    );

    csr_rd_mux #(.AFU_ID(AFU_ID)) i_csr_rd_mux (
        .clk, .reset, .local_rd, .rd_word, .rd_tid, .scratch, .sreg_addr,
        .held_valid, .held_tid, .held_data, .held_taken, .rsp_valid, .rsp_tid, .rsp_data
    );

    csr_wr_regs i_csr_wr_regs (
        .clk, .reset, .wr_en, .wr_word, .wr_data, .scratch, .sreg_addr
    );

    sreg_bridge i_sreg_bridge (
        .clk, .reset, .sreg_rd, .sreg_rd_tid, .file_rd_valid, .file_rd_data,
        .held_taken, .held_valid, .held_tid, .held_data
    );

    sreg_file #(.SREG_LATENCY(SREG_LATENCY)) i_sreg_file (
        .clk, .reset, .sreg_rd, .sreg_addr, .wr_en, .wr_word, .wr_data,
        .file_rd_valid, .file_rd_data
    );

endmodule

`default_nettype wire

// ==== rtl/csr_dispatch.sv ====
//////////////////////////////////////////////////
// CSR request dispatch
// Registers each host request and splits it into
// local read, sreg read and write strobes
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module csr_dispatch
    import csr_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       mmio_rd_valid,
    input  wire logic       mmio_wr_valid,
    input  wire t_mmio_addr mmio_addr,
    input  wire t_tid       mmio_tid,
    input  wire t_mmio_data mmio_wr_data,
    output logic            local_rd,
    output t_csr_word       rd_word,
    output t_tid            rd_tid,
    output logic            sreg_rd,
    output t_tid            sreg_rd_tid,
    output logic            wr_en,
    output t_csr_word       wr_word,
    output t_mmio_data      wr_data
);

    // Only words 0 to 7 are decoded so every higher address bit must be clear
    logic      in_range;
    t_csr_word req_word;

    assign in_range = (mmio_addr[15:4] == '0);
    // Bit 0 selects a 4-byte half and is not used by the 8-byte map
    assign req_word = mmio_addr[3:1];

    // Strobes last exactly one cycle behind the request
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            local_rd <= 1'b0;
            sreg_rd  <= 1'b0;
            wr_en    <= 1'b0;
        end
        else
        begin
            // The data window is the only word served by the sreg file
            local_rd <= mmio_rd_valid && in_range && (req_word != CSR_SREG_DATA);
            sreg_rd  <= mmio_rd_valid && in_range && (req_word == CSR_SREG_DATA);
            wr_en    <= mmio_wr_valid && in_range;
        end
    end

    // Request payload follows the strobes and is only loaded when a request arrives
    always_ff @(posedge clk)
    begin
        if (mmio_rd_valid)
        begin
            rd_word     <= req_word;
            rd_tid      <= mmio_tid;
            sreg_rd_tid <= mmio_tid;
        end
        if (mmio_wr_valid)
        begin
            wr_word <= req_word;
            wr_data <= mmio_wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/csr_rd_mux.sv ====
//////////////////////////////////////////////////
// CSR read response mux
// Answers local reads and forwards held sreg data
// on cycles when the response port is free
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module csr_rd_mux
    import csr_pkg::*;
    import sreg_pkg::*;
#(
    parameter logic [127:0] AFU_ID = 128'h1
)
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       local_rd,
    input  wire t_csr_word  rd_word,
    input  wire t_tid       rd_tid,
    input  wire t_mmio_data scratch,
    input  wire t_sreg_addr sreg_addr,
    input  wire logic       held_valid,
    input  wire t_tid       held_tid,
    input  wire t_sreg_data held_data,
    output logic            held_taken,
    output logic            rsp_valid,
    output t_tid            rsp_tid,
    output t_mmio_data      rsp_data
);

    // Device feature header with type and next offset set and all other fields zero
    localparam t_mmio_data AFU_DFH = {DFH_TYPE_AFU, 20'b0, DFH_NEXT_OFFSET, 16'b0};

    t_mmio_data local_data;

    // Local read value selected by word index
    always_comb
    begin
        case (rd_word)
            CSR_DFH:       local_data = AFU_DFH;
            CSR_ID_L:      local_data = AFU_ID[63:0];
            CSR_ID_H:      local_data = AFU_ID[127:64];
            CSR_SCRATCH:   local_data = scratch;
            CSR_SREG_ADDR: local_data = t_mmio_data'(sreg_addr);
            // Reserved words read as zero
            default:       local_data = '0;
        endcase
    end

    // A local read always owns the port so the sreg response waits behind it
    assign held_taken = held_valid && !local_rd;

    // One response strobe per cycle in which either source has something to send
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= local_rd || held_valid;
        end
    end

    // Tid and data come from the local read when present, else from the held sreg response
    always_ff @(posedge clk)
    begin
        if (local_rd)
        begin
            rsp_tid  <= rd_tid;
            rsp_data <= local_data;
        end
        else if (held_valid)
        begin
            rsp_tid  <= held_tid;
            rsp_data <= t_mmio_data'(held_data);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/csr_wr_regs.sv ====
//////////////////////////////////////////////////
// Host-writable CSRs
// Scratch register and sreg address register
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module csr_wr_regs
    import csr_pkg::*;
    import sreg_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       wr_en,
    input  wire t_csr_word  wr_word,
    input  wire t_mmio_data wr_data,
    output t_mmio_data      scratch,
    output t_sreg_addr      sreg_addr
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            scratch   <= '0;
            sreg_addr <= '0;
        end
        else if (wr_en)
        begin
            // Writes to any other word do not touch these registers
            if (wr_word == CSR_SCRATCH)
            begin
                scratch <= wr_data;
            end
            // Only the low bits needed to index the sreg file are kept
            if (wr_word == CSR_SREG_ADDR)
            begin
                sreg_addr <= wr_data[$bits(t_sreg_addr)-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
common/csr_pkg.sv
common/sreg_pkg.sv
rtl/csr_dispatch.sv
rtl/csr_rd_mux.sv
rtl/csr_wr_regs.sv
sreg/sreg_bridge.sv
sreg/sreg_file.sv
rtl/afu_csr_top.sv
verif/tb_clock.sv
verif/afu_csr_tb.sv

// ==== sreg/sreg_bridge.sv ====
//////////////////////////////////////////////////
// Sreg read bridge
// Tracks the outstanding sreg read and holds its
// data until the response port takes it
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module sreg_bridge
    import csr_pkg::*;
    import sreg_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       sreg_rd,
    input  wire t_tid       sreg_rd_tid,
    input  wire logic       file_rd_valid,
    input  wire t_sreg_data file_rd_data,
    input  wire logic       held_taken,
    output logic            held_valid,
    output t_tid            held_tid,
    output t_sreg_data      held_data
);

    // Set while a read is in the file pipeline and its data has not arrived
    logic pending;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pending    <= 1'b0;
            held_valid <= 1'b0;
        end
        else
        begin
            if (sreg_rd)
            begin
                pending <= 1'b1;
            end
            else if (file_rd_valid)
            begin
                pending <= 1'b0;
            end

            // The response stays as a level until the mux takes it
            if (held_taken)
            begin
                held_valid <= 1'b0;
            end
            else if (file_rd_valid && pending)
            begin
                held_valid <= 1'b1;
            end
        end
    end

    // Tid is recorded at issue and data is captured on arrival
    always_ff @(posedge clk)
    begin
        if (sreg_rd)
        begin
            held_tid <= sreg_rd_tid;
        end
        if (file_rd_valid && pending)
        begin
            held_data <= file_rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== sreg/sreg_file.sv ====
//////////////////////////////////////////////////
// System register file
// Storage behind the data window with a fixed
// latency read pipeline
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module sreg_file
    import csr_pkg::*;
    import sreg_pkg::*;
#(
    parameter int SREG_LATENCY = 3
)
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       sreg_rd,
    input  wire t_sreg_addr sreg_addr,
    input  wire logic       wr_en,
    input  wire t_csr_word  wr_word,
    input  wire t_mmio_data wr_data,
    output logic            file_rd_valid,
    output t_sreg_data      file_rd_data
);

    t_sreg_data regs [SREG_COUNT];

    // Read pipeline with one valid bit and one data word per stage
    logic [SREG_LATENCY-1:0] valid_pipe;
    t_sreg_data              data_pipe [SREG_LATENCY];

    // All system registers start at zero after reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < SREG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en && (wr_word == CSR_SREG_DATA))
        begin
            regs[sreg_addr] <= t_sreg_data'(wr_data);
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_pipe <= '0;
        end
        else
        begin
            valid_pipe[0] <= sreg_rd;
            for (int i = 1; i < SREG_LATENCY; i++)
            begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    // Data is sampled at the current sreg address when the read strobe arrives
    always_ff @(posedge clk)
    begin
        data_pipe[0] <= regs[sreg_addr];
        for (int i = 1; i < SREG_LATENCY; i++)
        begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign file_rd_valid = valid_pipe[SREG_LATENCY-1];
    assign file_rd_data  = data_pipe[SREG_LATENCY-1];

endmodule

`default_nettype wire

// ==== verif/afu_csr_tb.sv ====
//////////////////////////////////////////////////
// AFU CSR front end testbench
// Random MMIO traffic checked against a model
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module afu_csr_tb
    import csr_pkg::*;
;

    localparam logic [127:0] AFU_ID = 128'h5e21_0c9a_77d4_4f18_b3e6_29a0_c5d1_8f43;
    localparam int LAT = 3;
    localparam int NUM_MIX = 2000;
    // Upper bound on the directed requests issued before the random mix
    localparam int DIRECTED_REQS = 300;
    localparam int WATCHDOG_CYCLES = (NUM_MIX + DIRECTED_REQS) * 20 + 1000;

    logic clk;
    logic reset;
    logic mmio_rd_valid;
    logic mmio_wr_valid;
    t_mmio_addr mmio_addr;
    t_tid mmio_tid;
    t_mmio_data mmio_wr_data;
    logic rsp_valid;
    t_tid rsp_tid;
    t_mmio_data rsp_data;

    // Model state mirrored from the writes in issue order
    t_mmio_data m_scratch;
    logic [3:0] m_sreg_addr;
    t_mmio_data m_sregs [16];

    // Local read expectations, each due exactly two cycles after issue
    int due_q [$];
    t_tid tid_q [$];
    t_mmio_data data_q [$];
    string name_q [$];

    // The single outstanding sreg read
    logic sreg_pend;
    t_tid sreg_tid;
    t_mmio_data sreg_exp;
    int sreg_issue;
    string sreg_name;

    int cycle;
    int value_errors;
    int protocol_errors;
    int req_count;
    t_tid next_tid;
    string test_name;

    tb_clock #(.PERIOD_NS(8)) i_tb_clock (.clk);

    afu_csr_top #(.AFU_ID(AFU_ID), .SREG_LATENCY(LAT)) i_afu_csr_top (
        .clk, .reset, .mmio_rd_valid, .mmio_wr_valid, .mmio_addr, .mmio_tid, .mmio_wr_data,
        .rsp_valid, .rsp_tid, .rsp_data
    );

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    // Expected value of a local word read, straight from the register map
    function automatic t_mmio_data local_value(input t_csr_word w);
        case (w)
            3'd0: return (64'(DFH_TYPE_AFU) << 60) | (64'(DFH_NEXT_OFFSET) << 16);
            3'd1: return AFU_ID[63:0];
            3'd2: return AFU_ID[127:64];
            3'd5: return m_scratch;
            3'd6: return 64'(m_sreg_addr);
            default: return 64'd0;
        endcase
    endfunction

    // Drives one request for one cycle and records what the DUT must answer
    task automatic send_req(input logic is_rd, input t_mmio_addr addr, input t_mmio_data data);
        t_csr_word w;
        logic in_range;
        @(posedge clk);
        #1;
        w = addr[3:1];
        in_range = (addr[15:4] == 12'd0);
        mmio_rd_valid = is_rd;
        mmio_wr_valid = !is_rd;
        mmio_addr = addr;
        mmio_tid = next_tid;
        mmio_wr_data = data;
        if (in_range && is_rd && (w == 3'd7))
        begin
            sreg_pend = 1'b1;
            sreg_tid = next_tid;
            sreg_exp = m_sregs[m_sreg_addr];
            sreg_issue = cycle;
            sreg_name = test_name;
        end
        else if (in_range && is_rd)
        begin
            due_q.push_back(cycle + 2);
            tid_q.push_back(next_tid);
            data_q.push_back(local_value(w));
            name_q.push_back(test_name);
        end
        else if (in_range)
        begin
            // Writes to the header and reserved words change nothing
            case (w)
                3'd5: m_scratch = data;
                3'd6: m_sreg_addr = data[3:0];
                3'd7: m_sregs[m_sreg_addr] = data;
                default: ;
            endcase
        end
        next_tid++;
        req_count++;
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
            mmio_rd_valid = 1'b0;
            mmio_wr_valid = 1'b0;
        end
    endtask

    // Only one sreg read may be outstanding at a time
    task automatic wait_sreg_idle();
        while (sreg_pend)
        begin
            idle(1);
        end
    endtask

    function automatic t_mmio_addr word_addr(input t_csr_word w);
        return {12'd0, w, 1'($urandom)};
    endfunction

    function automatic t_mmio_data rand64();
        return {$urandom, $urandom};
    endfunction

    // Responses are sampled mid-cycle, well away from the clock edge
    always @(negedge clk)
    begin
        if (!reset && due_q.size() > 0 && due_q[0] <= cycle)
        begin
            assert (rsp_valid)
            else
            begin
                $display("%s: no response for local read tid %0d in cycle %0d",
                         name_q[0], tid_q[0], cycle);
                protocol_errors++;
            end
            if (rsp_valid)
            begin
                assert (rsp_tid == tid_q[0])
                else
                begin
                    $display("FAIL %s tid expected %0d actual %0d", name_q[0], tid_q[0], rsp_tid);
                    value_errors++;
                end
                assert (rsp_data == data_q[0])
                else
                begin
                    $display("FAIL %s data expected %h actual %h", name_q[0], data_q[0], rsp_data);
                    value_errors++;
                end
            end
            void'(due_q.pop_front());
            void'(tid_q.pop_front());
            void'(data_q.pop_front());
            void'(name_q.pop_front());
        end
        else if (!reset && rsp_valid)
        begin
            // Outside a local slot the only legal response is the pending sreg read
            assert (sreg_pend && rsp_tid == sreg_tid)
            else
            begin
                $display("Unexpected response with tid %0d in cycle %0d", rsp_tid, cycle);
                protocol_errors++;
            end
            if (sreg_pend && rsp_tid == sreg_tid)
            begin
                assert (cycle >= sreg_issue + LAT + 3)
                else
                begin
                    $display("%s: sreg response tid %0d came too early, %0d cycles after issue",
                             sreg_name, sreg_tid, cycle - sreg_issue);
                    protocol_errors++;
                end
                assert (rsp_data == sreg_exp)
                else
                begin
                    $display("FAIL %s data expected %h actual %h", sreg_name, sreg_exp, rsp_data);
                    value_errors++;
                end
                sreg_pend = 1'b0;
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles with the run still going", WATCHDOG_CYCLES);
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors + 1);
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        t_csr_word w;
        logic is_rd;
        t_mmio_addr addr;
        void'($urandom(32'h655cf985));
        reset = 1'b1;
        mmio_rd_valid = 1'b0;
        mmio_wr_valid = 1'b0;
        mmio_addr = '0;
        mmio_tid = '0;
        mmio_wr_data = '0;
        m_scratch = '0;
        m_sreg_addr = '0;
        foreach (m_sregs[i]) m_sregs[i] = '0;
        sreg_pend = 1'b0;
        cycle = 0;
        value_errors = 0;
        protocol_errors = 0;
        req_count = 0;
        next_tid = '0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        idle(2);

        test_name = "header";
        for (int i = 0; i < 9; i++)
        begin
            send_req(1'b1, word_addr(t_csr_word'(i % 3)), '0);
        end
        test_name = "reserved";
        send_req(1'b1, word_addr(3'd3), '0);
        send_req(1'b1, word_addr(3'd4), '0);
        // Any set bit above bit 3 must make the request vanish
        test_name = "out_of_range";
        repeat (8)
        begin
            addr = t_mmio_addr'($urandom) | (16'h10 << ($urandom % 12));
            send_req(1'($urandom), addr, rand64());
        end
        idle(10);

        test_name = "scratch_sreg_addr";
        repeat (20)
        begin
            send_req(1'b0, word_addr(($urandom % 2) ? 3'd5 : 3'd6), rand64());
            send_req(1'b1, word_addr(3'd5), '0);
            send_req(1'b1, word_addr(3'd6), '0);
        end
        idle(4);

        test_name = "sreg_path";
        repeat (20)
        begin
            send_req(1'b0, word_addr(3'd6), rand64());
            send_req(1'b0, word_addr(3'd7), rand64());
            wait_sreg_idle();
            send_req(1'b1, word_addr(3'd7), '0);
        end

        // Local reads keep the port busy while the sreg data is held
        test_name = "collision";
        repeat (10)
        begin
            wait_sreg_idle();
            send_req(1'b1, word_addr(3'd7), '0);
            repeat (LAT + 4)
            begin
                send_req(1'b1, word_addr(t_csr_word'($urandom % 7)), '0);
            end
        end

        test_name = "random_mix";
        for (int i = 0; i < NUM_MIX; i++)
        begin
            if ($urandom % 8 == 0)
            begin
                idle(1);
            end
            else
            begin
                w = t_csr_word'($urandom);
                is_rd = 1'($urandom);
                if (is_rd && w == 3'd7 && sreg_pend)
                    w = t_csr_word'($urandom % 7);
                addr = word_addr(w);
                if ($urandom % 16 == 0)
                    addr = addr | (16'h10 << ($urandom % 12));
                send_req(is_rd, addr, rand64());
            end
        end

        for (int i = 0; i < 100 && (due_q.size() > 0 || sreg_pend); i++)
        begin
            idle(1);
        end
        idle(10);
        assert (due_q.size() == 0 && !sreg_pend)
        else
        begin
            $display("Responses still outstanding at the end of the run");
            protocol_errors++;
        end

        $display("Errors: %0d value, %0d protocol over %0d requests",
                 value_errors, protocol_errors, req_count);
        if (value_errors == 0 && protocol_errors == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
//////////////////////////////////////////////////
// Testbench clock source
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 8
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
    end

    // Free-running clock with an even duty cycle
    always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

`default_nettype wire
